// ==== source/engine_pkg.sv ====
package engine_pkg;

	// width of one lane value and of every output word
	parameter int DATA_W = 16;

	// job operation, zero is not a valid job
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_CONV  = 2'd1, // multiply-accumulate, lane sum, bias, relu
		OP_MPOOL = 2'd2, // per-lane signed maximum
		OP_APOOL = 2'd3  // per-lane sum, then arithmetic shift
	} op_t;

endpackage

// ==== source/engine_ctrl.sv ====
`timescale 1ns/1ps

module engine_ctrl import engine_pkg::*; #(
	parameter int LANES = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic i_start,
	input  op_t  i_op,
	input  logic i_last_k,
	input  logic i_first_k,
	input  logic i_last_point,
	input  logic i_wr_last,
	output logic o_job_clear,
	output logic o_fetch_en,
	output logic o_next_point,
	output logic o_acc_en,
	output logic o_acc_first,
	output logic o_reduce_en,
	output logic o_wr_start,
	output logic o_busy,
	output logic o_done
);

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_FETCH  = 3'd1;
	localparam logic [2:0] S_DRAIN  = 3'd2;
	localparam logic [2:0] S_REDUCE = 3'd3;
	localparam logic [2:0] S_WRITE  = 3'd4;
	localparam logic [2:0] S_DONE   = 3'd5;

	logic [2:0] state;
	logic [2:0] state_nxt;
	logic       start_ok;

	assign start_ok = i_start && (i_op != OP_NONE);

	always_comb begin
		state_nxt = state;
		case (state)
			S_IDLE: begin
				if (start_ok)
					state_nxt = S_FETCH;
			end
			S_FETCH: begin
				if (i_last_k)
					state_nxt = S_DRAIN;
			end
			S_DRAIN:  state_nxt = S_REDUCE; // last word lands in the lanes
			S_REDUCE: state_nxt = S_WRITE;
			S_WRITE: begin
				if (i_wr_last)
					state_nxt = i_last_point ? S_DONE : S_FETCH;
			end
			S_DONE:   state_nxt = S_IDLE;
			default:  state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// accumulate strobes follow the memory latency by one cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_acc_en    <= 1'b0;
			o_acc_first <= 1'b0;
			o_wr_start  <= 1'b0;
		end else begin
			o_acc_en    <= o_fetch_en;
			o_acc_first <= o_fetch_en && i_first_k;
			o_wr_start  <= (state == S_REDUCE); // high in the first WRITE cycle
		end
	end

	assign o_job_clear  = (state == S_IDLE) && start_ok;
	assign o_fetch_en   = (state == S_FETCH);
	assign o_next_point = (state == S_WRITE) && i_wr_last && !i_last_point;
	assign o_reduce_en  = (state == S_REDUCE);
	assign o_busy       = (state != S_IDLE);
	assign o_done       = (state == S_DONE);

endmodule

// ==== source/engine_addr_gen.sv ====
`timescale 1ns/1ps

module engine_addr_gen #(
	parameter int ADDR_W = 10
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              i_job_clear,
	input  logic              i_fetch_en,
	input  logic              i_next_point,
	input  logic              i_busy,
	input  logic [7:0]        i_kernel_size,
	input  logic [7:0]        i_o_side,
	input  logic [7:0]        i_stride,
	output logic [ADDR_W-1:0] o_d_addr,
	output logic [ADDR_W-1:0] o_w_addr,
	output logic              o_first_k,
	output logic              o_last_k,
	output logic              o_last_point,
	output logic [31:0]       o_busy_cycles
);

	logic [7:0] k_cnt;  // kernel index within the point
	logic [7:0] p_cnt;  // output point index

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			k_cnt <= '0;
			p_cnt <= '0;
		end else if (i_job_clear) begin
			k_cnt <= '0;
			p_cnt <= '0;
		end else begin
			if (i_fetch_en)
				k_cnt <= o_last_k ? 8'd0 : k_cnt + 8'd1; // wraps for the next point
			if (i_next_point)
				p_cnt <= p_cnt + 8'd1;
		end
	end

	// busy cycles of the latest job, held until the next start
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_busy_cycles <= '0;
		end else if (i_job_clear) begin
			o_busy_cycles <= '0;
		end else if (i_busy) begin
			o_busy_cycles <= o_busy_cycles + 32'd1;
		end
	end

	assign o_first_k    = (k_cnt == 8'd0);
	assign o_last_k     = (k_cnt + 8'd1 == i_kernel_size);
	assign o_last_point = (p_cnt + 8'd1 == i_o_side);

	// window start is point * stride
	assign o_d_addr = ADDR_W'(p_cnt) * ADDR_W'(i_stride) + ADDR_W'(k_cnt);
	assign o_w_addr = ADDR_W'(k_cnt);

endmodule

// ==== source/lane_unit.sv ====
`timescale 1ns/1ps

module lane_unit import engine_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  op_t               i_op,
	input  logic              i_acc_en,
	input  logic              i_acc_first,
	input  logic [DATA_W-1:0] i_data,
	input  logic [DATA_W-1:0] i_weight,
	output logic [DATA_W-1:0] o_acc
);

	logic signed [2*DATA_W-1:0] prod;
	logic        [DATA_W-1:0]   term;

	assign prod = $signed(i_data) * $signed(i_weight);

	// convolution uses the wrapped product, pooling the raw value
	assign term = (i_op == OP_CONV) ? prod[DATA_W-1:0] : i_data;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_acc <= '0;
		end else if (i_acc_en) begin
			if (i_acc_first) begin
				o_acc <= term; // new window starts here
			end else begin
				case (i_op)
					OP_CONV, OP_APOOL: begin
						o_acc <= o_acc + term;
					end
					OP_MPOOL: begin
						if ($signed(term) > $signed(o_acc))
							o_acc <= term;
					end
					default: o_acc <= o_acc;
				endcase
			end
		end
	end

endmodule

// ==== source/lane_reduce.sv ====
`timescale 1ns/1ps

module lane_reduce import engine_pkg::*; #(
	parameter int LANES = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_reduce_en,
	input  logic [LANES*DATA_W-1:0] i_lane_acc,
	input  logic [DATA_W-1:0]       i_bias,
	output logic [DATA_W-1:0]       o_conv_result
);

	logic [DATA_W-1:0] sum;

	// adder tree flattened into a loop, wraps at DATA_W
	always_comb begin
		sum = i_bias;
		for (int n = 0; n < LANES; n++) begin
			sum = sum + i_lane_acc[n*DATA_W +: DATA_W];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			o_conv_result <= '0;
		end else if (i_reduce_en) begin
			o_conv_result <= sum[DATA_W-1] ? '0 : sum; // relu
		end
	end

endmodule

// ==== source/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback import engine_pkg::*; #(
	parameter int LANES = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_wr_start,
	input  op_t                     i_op,
	input  logic [DATA_W-1:0]       i_conv_result,
	input  logic [LANES*DATA_W-1:0] i_lane_acc,
	input  logic [3:0]              i_avg_shift,
	output logic                    o_out_valid,
	output logic [DATA_W-1:0]       o_out_data,
	output logic                    o_wr_last
);

	localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

	logic             active;    // words still pending after the first
	logic [IDX_W-1:0] cnt;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] last_idx;
	logic             writing;
	logic [DATA_W-1:0] lane_word;
	logic [DATA_W-1:0] word;

	assign writing  = i_wr_start || active;
	assign idx      = i_wr_start ? '0 : cnt;
	assign last_idx = (i_op == OP_CONV) ? '0 : IDX_W'(LANES - 1); // one word or one per lane
	assign o_wr_last = writing && (idx == last_idx);

	assign lane_word = i_lane_acc[idx*DATA_W +: DATA_W]; // lane 0 goes out first

	always_comb begin
		case (i_op)
			OP_CONV:  word = i_conv_result;
			OP_MPOOL: word = lane_word;
			OP_APOOL: word = $signed(lane_word) >>> i_avg_shift;
			default:  word = '0;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active      <= 1'b0;
			cnt         <= '0;
			o_out_valid <= 1'b0;
		end else begin
			o_out_valid <= writing;
			if (writing) begin
				cnt    <= idx + 1'b1;
				active <= !o_wr_last;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (writing)
			o_out_data <= word;
	end

endmodule

// ==== source/engine_top.sv ====
`timescale 1ns/1ps

module engine_top import engine_pkg::*; #(
	parameter int LANES  = 4,
	parameter int ADDR_W = 10
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    i_start,
	input  op_t                     i_op,
	input  logic [7:0]              i_kernel_size,
	input  logic [7:0]              i_o_side,
	input  logic [7:0]              i_stride,
	input  logic [DATA_W-1:0]       i_bias,
	input  logic [3:0]              i_avg_shift,
	output logic [ADDR_W-1:0]       o_d_addr,
	output logic [ADDR_W-1:0]       o_w_addr,
	input  logic [LANES*DATA_W-1:0] i_data,
	input  logic [LANES*DATA_W-1:0] i_weight,
	output logic                    o_out_valid,
	output logic [DATA_W-1:0]       o_out_data,
	output logic                    o_done,
	output logic                    o_busy,
	output logic [31:0]             o_busy_cycles
);

	logic job_clear;
	logic fetch_en;
	logic next_point;
	logic acc_en;
	logic acc_first;
	logic reduce_en;
	logic wr_start;
	logic wr_last;
	logic first_k;
	logic last_k;
	logic last_point;

	logic [LANES*DATA_W-1:0] lane_acc;
	logic [DATA_W-1:0]       conv_result;

	engine_ctrl #(
		.LANES (LANES)
	) ctrl_i (
		.clk          (clk),
		.rst          (rst),
		.i_start      (i_start),
		.i_op         (i_op),
		.i_last_k     (last_k),
		.i_first_k    (first_k),
		.i_last_point (last_point),
		.i_wr_last    (wr_last),
		.o_job_clear  (job_clear),
		.o_fetch_en   (fetch_en),
		.o_next_point (next_point),
		.o_acc_en     (acc_en),
		.o_acc_first  (acc_first),
		.o_reduce_en  (reduce_en),
		.o_wr_start   (wr_start),
		.o_busy       (o_busy),
		.o_done       (o_done)
	);

	engine_addr_gen #(
		.ADDR_W (ADDR_W)
	) addr_i (
		.clk           (clk),
		.rst           (rst),
		.i_job_clear   (job_clear),
		.i_fetch_en    (fetch_en),
		.i_next_point  (next_point),
		.i_busy        (o_busy),
		.i_kernel_size (i_kernel_size),
		.i_o_side      (i_o_side),
		.i_stride      (i_stride),
		.o_d_addr      (o_d_addr),
		.o_w_addr      (o_w_addr),
		.o_first_k     (first_k),
		.o_last_k      (last_k),
		.o_last_point  (last_point),
		.o_busy_cycles (o_busy_cycles)
	);

	// one accumulator per lane, all driven by the same strobes
	for (genvar n = 0; n < LANES; n++) begin : g_lane
		lane_unit lane_i (
			.clk         (clk),
			.rst         (rst),
			.i_op        (i_op),
			.i_acc_en    (acc_en),
			.i_acc_first (acc_first),
			.i_data      (i_data[n*DATA_W +: DATA_W]),
			.i_weight    (i_weight[n*DATA_W +: DATA_W]),
			.o_acc       (lane_acc[n*DATA_W +: DATA_W])
		);
	end

	lane_reduce #(
		.LANES (LANES)
	) reduce_i (
		.clk           (clk),
		.rst           (rst),
		.i_reduce_en   (reduce_en),
		.i_lane_acc    (lane_acc),
		.i_bias        (i_bias),
		.o_conv_result (conv_result)
	);

	result_writeback #(
		.LANES (LANES)
	) wb_i (
		.clk           (clk),
		.rst           (rst),
		.i_wr_start    (wr_start),
		.i_op          (i_op),
		.i_conv_result (conv_result),
		.i_lane_acc    (lane_acc),
		.i_avg_shift   (i_avg_shift),
		.o_out_valid   (o_out_valid),
		.o_out_data    (o_out_data),
		.o_wr_last     (wr_last)
	);

endmodule

// ==== bench/engine_props.sv ====
`timescale 1ns/1ps

module engine_props (
	input logic clk,
	input logic rst,
	input logic i_start,
	input logic o_done,
	input logic o_busy,
	input logic o_out_valid
);

	int fails = 0; // failed property count

	// done is a single pulse and the engine is idle right after it
	done_pulse: assert property (@(posedge clk) disable iff (rst)
		o_done |=> !o_done && !o_busy)
		else begin
			$error("o_done lasted more than one cycle or o_busy stayed high after it");
			fails++;
		end

	valid_in_busy: assert property (@(posedge clk) disable iff (rst)
		o_out_valid |-> o_busy)
		else begin
			$error("o_out_valid was high while o_busy was low");
			fails++;
		end

	// a job only begins the cycle after a start pulse
	busy_needs_start: assert property (@(posedge clk) disable iff (rst)
		$rose(o_busy) |-> $past(i_start))
		else begin
			$error("o_busy rose without a start pulse");
			fails++;
		end

endmodule

bind engine_top engine_props props_i (
	.clk         (clk),
	.rst         (rst),
	.i_start     (i_start),
	.o_done      (o_done),
	.o_busy      (o_busy),
	.o_out_valid (o_out_valid)
);

// ==== bench/engine_tb.sv ====
`timescale 1ns/1ps

module engine_tb import engine_pkg::*; ();

	localparam int LANES  = 4;
	localparam int ADDR_W = 10;

	logic                    clk;
	logic                    rst;
	logic                    i_start;
	op_t                     i_op;
	logic [7:0]              i_kernel_size;
	logic [7:0]              i_o_side;
	logic [7:0]              i_stride;
	logic [DATA_W-1:0]       i_bias;
	logic [3:0]              i_avg_shift;
	logic [ADDR_W-1:0]       o_d_addr;
	logic [ADDR_W-1:0]       o_w_addr;
	logic [LANES*DATA_W-1:0] i_data;
	logic [LANES*DATA_W-1:0] i_weight;
	logic                    o_out_valid;
	logic [DATA_W-1:0]       o_out_data;
	logic                    o_done;
	logic                    o_busy;
	logic [31:0]             o_busy_cycles;

	logic [LANES*DATA_W-1:0] data_mem [2**ADDR_W];
	logic [LANES*DATA_W-1:0] weight_mem [2**ADDR_W];
	logic [DATA_W-1:0]       exp_q [$]; // expected words of the running job
	logic [DATA_W-1:0]       exp_word;
	integer                  seed;
	int                      errors = 0;
	int                      words = 0;
	int                      passed = 0;
	int                      failed = 0;
	string                   test_name;

	engine_top #(.LANES(LANES), .ADDR_W(ADDR_W)) dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// memories answer one edge after the address
	always @(posedge clk) begin
		i_data   <= #1 data_mem[o_d_addr];
		i_weight <= #1 weight_mem[o_w_addr];
	end

	always @(negedge clk) begin
		if (!rst && o_out_valid) begin
			words++;
			assert (exp_q.size() > 0) else begin
				$display("%s: output word %h arrived with none expected", test_name, o_out_data);
				errors++;
			end
			if (exp_q.size() > 0) begin
				exp_word = exp_q.pop_front();
				assert (o_out_data == exp_word) else begin
					$display("FAILED %s: expected %h, actual %h", test_name, exp_word, o_out_data);
					errors++;
				end
			end
		end
	end

	function automatic int job_len(int w, int k, int side);
		return side * (k + 2 + w) + 1;
	endfunction

	// expected words from the memory arrays with 16-bit wrapping
	task automatic compute_expected(input op_t op, input int k, input int side, input int step,
			input logic [DATA_W-1:0] b, input int sh);
		logic [DATA_W-1:0]        acc [LANES];
		logic [DATA_W-1:0]        d;
		logic signed [DATA_W-1:0] s;
		for (int pt = 0; pt < side; pt++) begin
			s = b; // conv total starts from bias
			for (int n = 0; n < LANES; n++) begin
				acc[n] = (op == OP_MPOOL) ? {1'b1, {(DATA_W-1){1'b0}}} : '0;
				for (int j = 0; j < k; j++) begin
					d = data_mem[pt * step + j][n*DATA_W +: DATA_W];
					if (op == OP_CONV)
						acc[n] = acc[n] + d * weight_mem[j][n*DATA_W +: DATA_W];
					else if (op == OP_APOOL)
						acc[n] = acc[n] + d;
					else if ($signed(d) > $signed(acc[n]))
						acc[n] = d;
				end
				s = s + acc[n];
			end
			if (op == OP_CONV) begin
				exp_q.push_back((s < 0) ? '0 : s); // relu
			end else begin
				for (int n = 0; n < LANES; n++) begin
					d = acc[n];
					if (op == OP_APOOL)
						d = $signed(acc[n]) >>> sh;
					exp_q.push_back(d);
				end
			end
		end
	endtask

	task automatic pulse_start();
		i_start = 1'b1;
		@(posedge clk);
		#1 i_start = 1'b0;
	endtask

	// poke_at restarts mid-job and reset_at aborts it with a reset
	task automatic run_job(input string name, input op_t op, input int k, input int side,
			input int step, input logic [DATA_W-1:0] b, input int sh, input int poke_at,
			input int reset_at);
		int w;
		int err0;
		w = (op == OP_CONV) ? 1 : LANES;
		err0 = errors;
		test_name = name;
		words = 0;
		exp_q.delete();
		if (op != OP_NONE)
			compute_expected(op, k, side, step, b, sh);
		i_op = op;
		i_kernel_size = 8'(k);
		i_o_side = 8'(side);
		i_stride = 8'(step);
		i_bias = b;
		i_avg_shift = 4'(sh);
		pulse_start();
		if (poke_at > 0) begin
			repeat (poke_at) @(posedge clk);
			#1;
			pulse_start();
		end
		if (reset_at > 0) begin
			repeat (reset_at) @(posedge clk);
			#1 rst = 1'b1;
			repeat (2) @(posedge clk);
			#1 rst = 1'b0;
			@(negedge clk);
			assert (!o_out_valid && !o_busy && !o_done && o_busy_cycles == 0
				&& o_d_addr == 0 && o_w_addr == 0) else begin
				$display("%s: outputs or addresses not back to idle after reset", name);
				errors++;
			end
		end else if (op == OP_NONE) begin
			repeat (8) begin
				@(negedge clk);
				assert (!o_busy) else begin
					$display("%s: engine went busy on a start with operation 0", name);
					errors++;
				end
			end
		end else begin
			do @(negedge clk); while (!o_done);
			@(negedge clk);
			assert (words == side * w) else begin
				$display("FAILED %s: expected %0d words, actual %0d", name, side * w, words);
				errors++;
			end
			assert (o_busy_cycles == job_len(w, k, side)) else begin
				$display("FAILED %s: expected %0d busy cycles, actual %0d", name,
					job_len(w, k, side), o_busy_cycles);
				errors++;
			end
		end
		@(posedge clk);
		#1;
		if (errors == err0) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - err0);
		end
	endtask

	initial begin
		int budget;
		budget = 10 + job_len(1, 5, 6) + job_len(1, 3, 8) + job_len(LANES, 4, 5)
			+ job_len(LANES, 4, 4) + job_len(LANES, 6, 3) + job_len(1, 4, 4)
			+ job_len(LANES, 3, 4) + job_len(1, 4, 3) + 9 * 20; // margin per test
		repeat (budget) @(posedge clk);
		$display("watchdog: tests still running after %0d cycles, run stopped", budget);
		$display("Verification failed");
		$finish;
	end

	initial begin
		seed = 32'h31ba67f9;
		for (int a = 0; a < 2**ADDR_W; a++) begin
			for (int n = 0; n < LANES; n++) begin
				data_mem[a][n*DATA_W +: DATA_W]   = $random(seed);
				weight_mem[a][n*DATA_W +: DATA_W] = $random(seed);
			end
		end
		rst = 1'b1;
		i_start = 1'b0;
		i_op = OP_NONE;
		i_kernel_size = '0;
		i_o_side = '0;
		i_stride = '0;
		i_bias = '0;
		i_avg_shift = '0;
		i_data = '0;
		i_weight = '0;
		repeat (10) @(posedge clk);
		#1 rst = 1'b0;
		run_job("conv_bias_pos", OP_CONV, 5, 6, 2, 16'h0040, 0, 0, 0);
		run_job("conv_bias_neg", OP_CONV, 3, 8, 3, 16'hf000, 0, 0, 0);
		run_job("max_pool", OP_MPOOL, 4, 5, 3, 16'h0000, 0, 0, 0);
		run_job("avg_pool_shift2", OP_APOOL, 4, 4, 2, 16'h0000, 2, 0, 0);
		run_job("avg_pool_shift5", OP_APOOL, 6, 3, 1, 16'h0000, 5, 0, 0);
		run_job("start_while_busy", OP_CONV, 4, 4, 1, 16'h0010, 0, 6, 0);
		run_job("bad_op_start", OP_NONE, 4, 4, 1, 16'h0000, 0, 0, 0);
		run_job("reset_mid_job", OP_MPOOL, 3, 4, 1, 16'h0000, 0, 0, 12);
		run_job("after_reset", OP_CONV, 4, 3, 2, 16'hff00, 0, 0, 0);
		$display("tests passed: %0d, failed: %0d, property failures: %0d", passed, failed,
			dut_i.props_i.fails);
		if (failed == 0 && dut_i.props_i.fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
source/engine_pkg.sv
source/engine_ctrl.sv
source/engine_addr_gen.sv
source/lane_unit.sv
source/lane_reduce.sv
source/result_writeback.sv
source/engine_top.sv
bench/engine_props.sv
bench/engine_tb.sv
